//--- design/soc_tcdm_pkg.sv
package soc_tcdm_pkg;

    ////////////////////
    // Port counts
    ////////////////////

    // Master 0 is the FC data port, the only one with the legacy alias
    localparam int NR_MASTERS  = 4;
    localparam int NR_L2_BANKS = 4;
    // Contiguous slaves sit right after the interleaved banks
    localparam int SLV_PRIVATE = 4;
    localparam int SLV_BOOTROM = 5;
    localparam int NR_SLAVES   = 6;
    localparam int SLV_IDX_W   = 3;
    localparam int MST_IDX_W   = 2;

    ////////////////////
    // Memory map
    ////////////////////

    // Word interleaved L2, bank taken from address bits 3 to 2
    localparam logic [31:0] L2_START   = 32'h1C01_0000;
    localparam logic [31:0] L2_END     = 32'h1C08_FFFF;
    localparam logic [31:0] PRIV_START = 32'h1C00_0000;
    localparam logic [31:0] PRIV_END   = 32'h1C00_FFFF;
    localparam logic [31:0] ROM_START  = 32'h1A00_0000;
    localparam logic [31:0] ROM_END    = 32'h1A00_1FFF;
    // Zero top prefix on master 0 maps onto this one
    localparam logic [11:0] ALIAS_PREFIX = 12'h1C0;
    // Read data returned for unmapped accesses
    localparam logic [31:0] ERR_RDATA = 32'hBADA_CCE5;

    typedef logic [SLV_IDX_W-1:0] slv_idx_t;
    typedef logic [MST_IDX_W-1:0] mst_idx_t;

    ////////////////////
    // Bus structs
    ////////////////////

    // TCDM request, wen low means write
    typedef struct packed {
        logic        req;
        logic        wen;
        logic [31:0] add;
        logic [31:0] wdata;
        logic [3:0]  be;
    } tcdm_req_t;

    typedef struct packed {
        logic        gnt;
        logic        r_valid;
        logic [31:0] r_rdata;
    } tcdm_rsp_t;

    // Read response of a slave, also used for the error responder
    typedef struct packed {
        logic        r_valid;
        logic [31:0] r_rdata;
    } slv_rsp_t;

    // Decoded request of one master
    typedef struct packed {
        logic      valid;
        logic      err;
        slv_idx_t  slv;
        tcdm_req_t req;
    } route_t;

    // Master that owns a slave transfer
    typedef struct packed {
        logic     valid;
        mst_idx_t mst;
    } winner_t;

endpackage

//--- design/tcdm_addr_decoder.sv
`timescale 1ns/1ps

module tcdm_addr_decoder (
    input  logic                                                      clk_i,
    input  logic                                                      rst_i,
    input  soc_tcdm_pkg::tcdm_req_t [soc_tcdm_pkg::NR_MASTERS-1:0]    mst_req_i,
    output logic [soc_tcdm_pkg::NR_MASTERS-1:0]                       mst_gnt_o,
    output soc_tcdm_pkg::route_t [soc_tcdm_pkg::NR_MASTERS-1:0]       route_o,
    input  logic [soc_tcdm_pkg::NR_SLAVES-1:0][soc_tcdm_pkg::NR_MASTERS-1:0] arb_gnt_i,
    output soc_tcdm_pkg::slv_rsp_t [soc_tcdm_pkg::NR_MASTERS-1:0]     err_rsp_o
);

    // Unmapped requests, granted right away
    logic [soc_tcdm_pkg::NR_MASTERS-1:0] err_gnt;
    // Error response pending for the next cycle
    logic [soc_tcdm_pkg::NR_MASTERS-1:0] err_valid_q;

    ////////////////////
    // Remap and decode
    ////////////////////
    always_comb begin
        logic [31:0] addr;
        for (int m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin
            route_o[m]       = '0;
            route_o[m].valid = mst_req_i[m].req;
            route_o[m].req   = mst_req_i[m];
            // Legacy alias, FC data only: 0x000xxxxx goes to 0x1C0xxxxx
            if (m == 0 && mst_req_i[m].add[31:20] == 12'h000) begin
                route_o[m].req.add[31:20] = soc_tcdm_pkg::ALIAS_PREFIX;
            end
            addr = route_o[m].req.add;
            // Region match on the remapped address
            if (addr >= soc_tcdm_pkg::L2_START && addr <= soc_tcdm_pkg::L2_END) begin
                // Word interleaving across the L2 banks
                route_o[m].slv = soc_tcdm_pkg::slv_idx_t'(addr[3:2]);
            end else if (addr >= soc_tcdm_pkg::PRIV_START &&
                         addr <= soc_tcdm_pkg::PRIV_END) begin
                route_o[m].slv = soc_tcdm_pkg::slv_idx_t'(soc_tcdm_pkg::SLV_PRIVATE);
            end else if (addr >= soc_tcdm_pkg::ROM_START &&
                         addr <= soc_tcdm_pkg::ROM_END) begin
                route_o[m].slv = soc_tcdm_pkg::slv_idx_t'(soc_tcdm_pkg::SLV_BOOTROM);
            end else begin
                // Nothing mapped here, answered locally
                route_o[m].err = mst_req_i[m].req;
            end
            err_gnt[m] = route_o[m].err;
        end
    end

    ////////////////////
    // Grant merge
    ////////////////////
    // At most one arbiter grants a given master per cycle
    always_comb begin
        for (int m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin
            mst_gnt_o[m] = err_gnt[m];
            for (int s = 0; s < soc_tcdm_pkg::NR_SLAVES; s++) begin
                mst_gnt_o[m] |= arb_gnt_i[s][m];
            end
        end
    end

    ////////////////////
    // Error responder
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            err_valid_q <= '0;
        end else begin
            err_valid_q <= err_gnt;
        end
    end

    // Fixed error word, one cycle after the error grant
    always_comb begin
        for (int m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin
            err_rsp_o[m].r_valid = err_valid_q[m];
            err_rsp_o[m].r_rdata = soc_tcdm_pkg::ERR_RDATA;
        end
    end

endmodule

//--- design/tcdm_bank_arbiter.sv
`timescale 1ns/1ps

module tcdm_bank_arbiter #(
    parameter int SLV_ID = 0
) (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  soc_tcdm_pkg::route_t [soc_tcdm_pkg::NR_MASTERS-1:0] route_i,
    output soc_tcdm_pkg::tcdm_req_t                             slv_req_o,
    input  logic                                                slv_gnt_i,
    output logic [soc_tcdm_pkg::NR_MASTERS-1:0]                 mst_gnt_o,
    output soc_tcdm_pkg::winner_t                               winner_o
);

    // Masters targeting this slave port
    logic [soc_tcdm_pkg::NR_MASTERS-1:0] cand;
    // Round-robin pointer, first master to look at
    soc_tcdm_pkg::mst_idx_t rr_q;
    // Choice held across a stalled transfer
    soc_tcdm_pkg::winner_t lock_q;
    logic sel_found;
    soc_tcdm_pkg::mst_idx_t sel_idx;
    logic xfer;

    ////////////////////
    // Request filter
    ////////////////////
    always_comb begin
        for (int m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin
            cand[m] = route_i[m].valid && !route_i[m].err &&
                      route_i[m].slv == soc_tcdm_pkg::slv_idx_t'(SLV_ID);
        end
    end

    ////////////////////
    // Selection
    ////////////////////
    always_comb begin
        int idx;
        sel_found = 1'b0;
        sel_idx   = rr_q;
        // Scan from the pointer upwards, wrapping around
        for (int i = 0; i < soc_tcdm_pkg::NR_MASTERS; i++) begin
            idx = (int'(rr_q) + i) % soc_tcdm_pkg::NR_MASTERS;
            if (!sel_found && cand[idx]) begin
                sel_found = 1'b1;
                sel_idx   = soc_tcdm_pkg::mst_idx_t'(idx);
            end
        end
        // A stalled request keeps the port until it is granted
        if (lock_q.valid) begin
            sel_idx   = lock_q.mst;
            sel_found = cand[lock_q.mst];
        end
    end

    // Forward the chosen request, idle bus otherwise
    assign slv_req_o = sel_found ? route_i[sel_idx].req : '0;
    assign xfer      = sel_found && slv_gnt_i;

    always_comb begin
        mst_gnt_o = '0;
        if (sel_found) begin
            mst_gnt_o[sel_idx] = slv_gnt_i;
        end
    end

    ////////////////////
    // State update
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rr_q     <= '0;
            lock_q   <= '0;
            winner_o <= '0;
        end else begin
            // Winner record lines up with the slave's r_valid
            winner_o.valid <= xfer;
            if (xfer) begin
                winner_o.mst <= sel_idx;
                // Move past the winner so everybody gets a turn
                rr_q <= soc_tcdm_pkg::mst_idx_t'((int'(sel_idx) + 1) %
                                                 soc_tcdm_pkg::NR_MASTERS);
            end
            lock_q.valid <= sel_found && !slv_gnt_i;
            if (sel_found) begin
                lock_q.mst <= sel_idx;
            end
        end
    end

endmodule

//--- design/tcdm_rsp_router.sv
`timescale 1ns/1ps

module tcdm_rsp_router (
    input  soc_tcdm_pkg::winner_t [soc_tcdm_pkg::NR_SLAVES-1:0]   winner_i,
    input  soc_tcdm_pkg::slv_rsp_t [soc_tcdm_pkg::NR_SLAVES-1:0]  slv_rsp_i,
    input  soc_tcdm_pkg::slv_rsp_t [soc_tcdm_pkg::NR_MASTERS-1:0] err_rsp_i,
    output soc_tcdm_pkg::slv_rsp_t [soc_tcdm_pkg::NR_MASTERS-1:0] mst_rsp_o
);

    ////////////////////
    // Response select
    ////////////////////

    // One grant per master and cycle, so one source matches at most
    always_comb begin
        for (int m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin
            mst_rsp_o[m] = '0;
            // Unmapped access answered by the decoder
            if (err_rsp_i[m].r_valid) begin
                mst_rsp_o[m] = err_rsp_i[m];
            end
            // Slave whose last transfer belonged to this master
            for (int s = 0; s < soc_tcdm_pkg::NR_SLAVES; s++) begin
                if (winner_i[s].valid &&
                    winner_i[s].mst == soc_tcdm_pkg::mst_idx_t'(m)) begin
                    mst_rsp_o[m].r_valid = slv_rsp_i[s].r_valid;
                    mst_rsp_o[m].r_rdata = slv_rsp_i[s].r_rdata;
                end
            end
        end
    end

endmodule

//--- design/soc_tcdm_interconnect.sv
`timescale 1ns/1ps

module soc_tcdm_interconnect (
    input  logic                                                    clk_i,
    input  logic                                                    rst_i,
    input  soc_tcdm_pkg::tcdm_req_t [soc_tcdm_pkg::NR_MASTERS-1:0]  mst_req_i,
    output soc_tcdm_pkg::tcdm_rsp_t [soc_tcdm_pkg::NR_MASTERS-1:0]  mst_rsp_o,
    output soc_tcdm_pkg::tcdm_req_t [soc_tcdm_pkg::NR_SLAVES-1:0]   slv_req_o,
    input  logic [soc_tcdm_pkg::NR_SLAVES-1:0]                      slv_gnt_i,
    input  soc_tcdm_pkg::slv_rsp_t [soc_tcdm_pkg::NR_SLAVES-1:0]    slv_rsp_i
);

    // Merged grant per master
    logic [soc_tcdm_pkg::NR_MASTERS-1:0] mst_gnt;
    soc_tcdm_pkg::route_t [soc_tcdm_pkg::NR_MASTERS-1:0] route;
    // One-hot grant vector of every arbiter
    logic [soc_tcdm_pkg::NR_SLAVES-1:0][soc_tcdm_pkg::NR_MASTERS-1:0] arb_gnt;
    soc_tcdm_pkg::slv_rsp_t [soc_tcdm_pkg::NR_MASTERS-1:0] err_rsp;
    soc_tcdm_pkg::winner_t [soc_tcdm_pkg::NR_SLAVES-1:0] winner;
    soc_tcdm_pkg::slv_rsp_t [soc_tcdm_pkg::NR_MASTERS-1:0] mst_r;

    ////////////////////
    // Decoder
    ////////////////////
    tcdm_addr_decoder u_decoder (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .mst_req_i (mst_req_i),
        .mst_gnt_o (mst_gnt),
        .route_o   (route),
        .arb_gnt_i (arb_gnt),
        .err_rsp_o (err_rsp)
    );

    ////////////////////
    // Slave arbiters
    ////////////////////
    for (genvar s = 0; s < soc_tcdm_pkg::NR_SLAVES; s++) begin : g_arb
        tcdm_bank_arbiter #(
            .SLV_ID (s)
        ) u_arbiter (
            .clk_i     (clk_i),
            .rst_i     (rst_i),
            .route_i   (route),
            .slv_req_o (slv_req_o[s]),
            .slv_gnt_i (slv_gnt_i[s]),
            .mst_gnt_o (arb_gnt[s]),
            .winner_o  (winner[s])
        );
    end

    ////////////////////
    // Response path
    ////////////////////
    tcdm_rsp_router u_router (
        .winner_i  (winner),
        .slv_rsp_i (slv_rsp_i),
        .err_rsp_i (err_rsp),
        .mst_rsp_o (mst_r)
    );

    // Gnt from the decoder, read response from the router
    for (genvar m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin : g_rsp
        assign mst_rsp_o[m].gnt     = mst_gnt[m];
        assign mst_rsp_o[m].r_valid = mst_r[m].r_valid;
        assign mst_rsp_o[m].r_rdata = mst_r[m].r_rdata;
    end

endmodule

//--- tb/soc_tcdm_interconnect_assertions.sv
`timescale 1ns/1ps

module soc_tcdm_interconnect_assertions (
    input logic                                                   clk_i,
    input logic                                                   rst_i,
    input soc_tcdm_pkg::tcdm_rsp_t [soc_tcdm_pkg::NR_MASTERS-1:0] mst_rsp_i,
    input soc_tcdm_pkg::tcdm_req_t [soc_tcdm_pkg::NR_SLAVES-1:0]  slv_req_i,
    input logic [soc_tcdm_pkg::NR_SLAVES-1:0]                     slv_gnt_i
);

    // Failed assertions, read by the testbench at the end
    int unsigned fail_cnt = 0;

    ////////////////////
    // Master side
    ////////////////////
    for (genvar m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin : g_mst
        // Read response exactly one cycle after the grant
        a_rsp_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
            mst_rsp_i[m].gnt |=> mst_rsp_i[m].r_valid)
            else begin
                $error("master %0d has no r_valid one cycle after its gnt", m);
                fail_cnt++;
            end
        // Every response belongs to a grant of the cycle before
        a_no_orphan_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
            mst_rsp_i[m].r_valid |-> $past(mst_rsp_i[m].gnt))
            else begin
                $error("master %0d has r_valid without a gnt before it", m);
                fail_cnt++;
            end
        a_quiet_in_reset: assert property (@(posedge clk_i)
            rst_i |-> !mst_rsp_i[m].gnt && !mst_rsp_i[m].r_valid)
            else begin
                $error("master %0d has gnt or r_valid high during reset", m);
                fail_cnt++;
            end
    end

    ////////////////////
    // Slave side
    ////////////////////
    for (genvar s = 0; s < soc_tcdm_pkg::NR_SLAVES; s++) begin : g_slv
        // Stalled request keeps all its fields
        a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
            slv_req_i[s].req && !slv_gnt_i[s] |=> $stable(slv_req_i[s]))
            else begin
                $error("slave %0d request changed while stalled", s);
                fail_cnt++;
            end
    end

endmodule

bind soc_tcdm_interconnect soc_tcdm_interconnect_assertions u_assertions (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .mst_rsp_i (mst_rsp_o),
    .slv_req_i (slv_req_o),
    .slv_gnt_i (slv_gnt_i)
);

//--- tb/tb_soc_tcdm_interconnect.sv
`timescale 1ns/1ps

module tb_soc_tcdm_interconnect;

    // Transactions per master
    localparam int NR_TXN      = 60;
    // Cycles a single transaction may wait at worst
    localparam int STALL_BOUND = 16;
    localparam int LIMIT       = NR_TXN * soc_tcdm_pkg::NR_MASTERS * STALL_BOUND + 200;

    logic clk;
    logic rst;
    soc_tcdm_pkg::tcdm_req_t [soc_tcdm_pkg::NR_MASTERS-1:0] mst_req;
    soc_tcdm_pkg::tcdm_rsp_t [soc_tcdm_pkg::NR_MASTERS-1:0] mst_rsp;
    soc_tcdm_pkg::tcdm_req_t [soc_tcdm_pkg::NR_SLAVES-1:0]  slv_req;
    logic [soc_tcdm_pkg::NR_SLAVES-1:0]                     slv_gnt;
    soc_tcdm_pkg::slv_rsp_t [soc_tcdm_pkg::NR_SLAVES-1:0]   slv_rsp;

    logic [31:0] lfsr_q = 32'haced;
    int          errors = 0;
    int          checks = 0;
    int          n_rsp  = 0;
    int unsigned cyc    = 0;
    // Reference memory keyed by full remapped address
    logic [31:0] ref_mem [logic [31:0]];
    // Outstanding responses per master, {is_read, data} and grant cycle
    logic [32:0] exp_q [soc_tcdm_pkg::NR_MASTERS][$];
    int unsigned gcyc_q [soc_tcdm_pkg::NR_MASTERS][$];
    // Slave model storage, word index from address bits 9 to 2
    logic [31:0] slv_mem [soc_tcdm_pkg::NR_SLAVES][256];
    bit          slv_wr [soc_tcdm_pkg::NR_SLAVES][256];
    logic [soc_tcdm_pkg::NR_SLAVES-1:0] pend_v;
    logic [31:0] pend_d [soc_tcdm_pkg::NR_SLAVES];

    soc_tcdm_interconnect u_dut (
        .clk_i     (clk),
        .rst_i     (rst),
        .mst_req_i (mst_req),
        .mst_rsp_o (mst_rsp),
        .slv_req_o (slv_req),
        .slv_gnt_i (slv_gnt),
        .slv_rsp_i (slv_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////
    // Helpers
    ////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v     = {v[30:0], fb};
        end
        return v;
    endfunction

    // Content of a word never written
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'hC3A5_96E1;
    endfunction

    function automatic logic [31:0] merge_be(input logic [31:0] old, input logic [31:0] wdata,
                                             input logic [3:0] be);
        logic [31:0] v;
        v = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) v[8*b +: 8] = wdata[8*b +: 8];
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    // Small word pool per region, L2 drawn most often for contention
    function automatic logic [31:0] pick_addr();
        logic [2:0]  region;
        logic [31:0] word;
        region = 3'(rand_bits(3));
        word   = {26'd0, 4'(rand_bits(4)), 2'b00};
        case (region)
            3'd0, 3'd1, 3'd2: return soc_tcdm_pkg::L2_START + word;
            3'd3:             return soc_tcdm_pkg::PRIV_START + word;
            3'd4:             return soc_tcdm_pkg::ROM_START + word;
            // Zero prefix, alias of the private bank on master 0 only
            3'd5:             return word;
            3'd6:             return soc_tcdm_pkg::L2_END + 32'd1 + word;
            default:          return 32'h3000_0000 + word;
        endcase
    endfunction

    // Memory map as seen by master m
    function automatic void decode_addr(input int m, input logic [31:0] add,
                                        output logic [31:0] radd, output int slv,
                                        output logic err);
        radd = add;
        slv  = 0;
        err  = 1'b0;
        if (m == 0 && add[31:20] == 12'h000) radd[31:20] = soc_tcdm_pkg::ALIAS_PREFIX;
        if (radd >= soc_tcdm_pkg::L2_START && radd <= soc_tcdm_pkg::L2_END) begin
            slv = int'(radd[3:2]);
        end else if (radd >= soc_tcdm_pkg::PRIV_START && radd <= soc_tcdm_pkg::PRIV_END) begin
            slv = soc_tcdm_pkg::SLV_PRIVATE;
        end else if (radd >= soc_tcdm_pkg::ROM_START && radd <= soc_tcdm_pkg::ROM_END) begin
            slv = soc_tcdm_pkg::SLV_BOOTROM;
        end else begin
            err = 1'b1;
        end
    endfunction

    task automatic check_value(input string name, input logic [69:0] exp,
                               input logic [69:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    ////////////////////
    // Master sequences
    ////////////////////
    task automatic run_master(input int m);
        soc_tcdm_pkg::tcdm_req_t r;
        soc_tcdm_pkg::tcdm_req_t fwd;
        logic [31:0] radd;
        logic [32:0] exp;
        logic        err;
        int          slv;
        int          others;
        int          waited;
        bit          done;
        for (int t = 0; t < NR_TXN; t++) begin
            r.req   = 1'b1;
            r.wen   = 1'(rand_bits(1));
            r.add   = pick_addr();
            r.wdata = rand_bits(32);
            r.be    = 4'(rand_bits(4));
            decode_addr(m, r.add, radd, slv, err);
            fwd     = r;
            fwd.add = radd;
            mst_req[m] = r;
            done   = 1'b0;
            others = 0;
            waited = 0;
            while (!done) begin
                @(negedge clk);
                if (mst_rsp[m].gnt) begin
                    done = 1'b1;
                    if (err) begin
                        // Unmapped, granted at once and never forwarded
                        check_value($sformatf("unmapped gnt wait m%0d", m), 70'd0, 70'(waited));
                        for (int s = 0; s < soc_tcdm_pkg::NR_SLAVES; s++) begin
                            if (slv_req[s].req && slv_req[s].add == r.add) begin
                                $display("unmapped address %h of master %0d reached slave %0d",
                                         r.add, m, s);
                                errors++;
                            end
                        end
                        exp = {r.wen, soc_tcdm_pkg::ERR_RDATA};
                    end else begin
                        // Request must sit on the decoded slave port, alias applied
                        check_value($sformatf("route m%0d", m), fwd, slv_req[slv]);
                        check_value($sformatf("slave gnt m%0d", m), 70'd1, 70'(slv_gnt[slv]));
                        if (others > soc_tcdm_pkg::NR_MASTERS - 1) begin
                            $display("master %0d waited through %0d grants to others on slave %0d",
                                     m, others, slv);
                            errors++;
                        end
                        exp = {r.wen, ref_read(radd)};
                        if (!r.wen) ref_mem[radd] = merge_be(ref_read(radd), r.wdata, r.be);
                    end
                    exp_q[m].push_back(exp);
                    gcyc_q[m].push_back(cyc);
                end else begin
                    waited++;
                    // Transfer on our slave that went to another master
                    if (!err && slv_gnt[slv] && slv_req[slv].req) others++;
                end
                @(posedge clk);
                #1;
            end
            // Idle cycle now and then
            if (rand_bits(2) == 32'd0) begin
                mst_req[m] = '0;
                @(posedge clk);
                #1;
            end
        end
        mst_req[m] = '0;
    endtask

    ////////////////////
    // Slave models
    ////////////////////
    initial begin
        logic [7:0]  idx;
        logic [31:0] old;
        slv_gnt = '0;
        slv_rsp = '0;
        pend_v  = '0;
        forever begin
            @(posedge clk);
            #1;
            for (int s = 0; s < soc_tcdm_pkg::NR_SLAVES; s++) begin
                // Answer the transfer granted in the last cycle
                slv_rsp[s].r_valid = pend_v[s];
                slv_rsp[s].r_rdata = pend_d[s];
                // Stall about one cycle in four
                slv_gnt[s] = !rst && (rand_bits(2) != 32'd0);
            end
            @(negedge clk);
            for (int s = 0; s < soc_tcdm_pkg::NR_SLAVES; s++) begin
                pend_v[s] = slv_req[s].req && slv_gnt[s];
                if (pend_v[s]) begin
                    idx       = slv_req[s].add[9:2];
                    old       = slv_wr[s][idx] ? slv_mem[s][idx] : fill_word(slv_req[s].add);
                    pend_d[s] = old;
                    if (!slv_req[s].wen) begin
                        slv_mem[s][idx] = merge_be(old, slv_req[s].wdata, slv_req[s].be);
                        slv_wr[s][idx]  = 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Response checker
    ////////////////////
    always @(negedge clk) begin
        logic [32:0] e;
        int unsigned g;
        if (!rst) begin
            for (int m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin
                if (mst_rsp[m].r_valid) begin
                    if (exp_q[m].size() == 0) begin
                        $display("master %0d got r_valid with no transfer outstanding", m);
                        errors++;
                    end else begin
                        // Oldest grant of this master answers first
                        e = exp_q[m].pop_front();
                        g = gcyc_q[m].pop_front();
                        n_rsp++;
                        check_value($sformatf("latency m%0d", m), 70'(g + 1), 70'(cyc));
                        if (e[32]) begin
                            check_value($sformatf("read data m%0d", m), 70'(e[31:0]),
                                        70'(mst_rsp[m].r_rdata));
                        end
                    end
                end
            end
        end
    end

    // Bound on the run length, every transaction stalled at worst
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", LIMIT);
        $display("Something failed");
        $finish;
    end

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        rst     = 1'b1;
        mst_req = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
        fork
            run_master(0);
            run_master(1);
            run_master(2);
            run_master(3);
        join
        repeat (3) @(negedge clk);
        for (int m = 0; m < soc_tcdm_pkg::NR_MASTERS; m++) begin
            if (exp_q[m].size() != 0) begin
                $display("master %0d never got %0d of its responses", m, exp_q[m].size());
                errors++;
            end
        end
        errors += int'(u_dut.u_assertions.fail_cnt);
        $display("%0d errors in %0d checks, %0d responses", errors, checks, n_rsp);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- Bender.yml
package:
  name: soc_tcdm_interconnect

sources:
  - design/soc_tcdm_pkg.sv
  - design/tcdm_addr_decoder.sv
  - design/tcdm_bank_arbiter.sv
  - design/tcdm_rsp_router.sv
  - design/soc_tcdm_interconnect.sv
  - target: test
    files:
      - tb/soc_tcdm_interconnect_assertions.sv
      - tb/tb_soc_tcdm_interconnect.sv

//--- sources.f
design/soc_tcdm_pkg.sv
design/tcdm_addr_decoder.sv
design/tcdm_bank_arbiter.sv
design/tcdm_rsp_router.sv
design/soc_tcdm_interconnect.sv
tb/soc_tcdm_interconnect_assertions.sv
tb/tb_soc_tcdm_interconnect.sv
